// ==== source/ipguPkg.sv ====
package ipguPkg;

    ////////////////////////////////////////
    // Fixed widths
    ////////////////////////////////////////

    localparam int PIX_W   = 8;
    localparam int ADDR_W  = 10;
    localparam int SCALE_W = 2;

    // Pixels per output window
    localparam int WIN_PIX = 16;
    localparam int WIN_W   = WIN_PIX * PIX_W;

    // Greyscale pixel, frame address, scale shift
    typedef logic [PIX_W-1:0]   pixel_t;
    typedef logic [ADDR_W-1:0]  pixAddr_t;
    typedef logic [SCALE_W-1:0] scale_t;

    // Pixel 0 in the low byte
    typedef logic [WIN_W-1:0]   window_t;

    ////////////////////////////////////////
    // Access structs
    ////////////////////////////////////////

    // Host direct port, 20 bits
    typedef struct packed {
        logic     sel;
        logic     we;
        pixAddr_t addr;
        pixel_t   data;
    } hostAccess_t;

    // Internal read request, 13 bits
    typedef struct packed {
        logic     en;
        pixAddr_t addr;
        logic     windowLast;
        logic     imageLast;
    } frameRead_t;

    // Job FSM
    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        DRAIN,
        DONE
    } ctrlState_t;

endpackage

// ==== source/frameRam.sv ====
module frameRam #(
    parameter int IMG_SIDE_LOG2 = 5
) (
    input  logic                 clk,
    input  ipguPkg::hostAccess_t hostAccess,
    output ipguPkg::pixel_t      hostRdData,
    input  ipguPkg::frameRead_t  readReq,
    output ipguPkg::pixel_t      rdData,
    output logic                 rdValid,
    output logic                 rdWindowLast,
    output logic                 rdImageLast
);

    // Square frame, one pixel per word
    localparam int MEM_ADDR_W = 2 * IMG_SIDE_LOG2;
    localparam int DEPTH      = 2 ** MEM_ADDR_W;

    ipguPkg::pixel_t mem [0:DEPTH-1];
    ipguPkg::pixel_t rdQ;

    // Single port, host wins
    logic [MEM_ADDR_W-1:0] memAddr;
    logic                  intRead;

    assign memAddr = hostAccess.sel ? hostAccess.addr[MEM_ADDR_W-1:0]
                                    : readReq.addr[MEM_ADDR_W-1:0];

    // Internal read dropped when the host selects
    assign intRead = readReq.en & ~hostAccess.sel;

    ////////////////////////////////////////
    // Memory array
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (hostAccess.sel && hostAccess.we) begin
            mem[memAddr] <= hostAccess.data;
        end else if (hostAccess.sel || readReq.en) begin
            rdQ <= mem[memAddr];
        end
    end

    // Tags follow the data by one cycle
    always_ff @(posedge clk) begin
        rdValid      <= intRead;
        rdWindowLast <= intRead & readReq.windowLast;
        rdImageLast  <= intRead & readReq.imageLast;
    end

    // Same read register feeds both sides
    assign hostRdData = rdQ;
    assign rdData     = rdQ;

endmodule

// ==== source/ipguAddrCompute.sv ====
module ipguAddrCompute #(
    parameter int IMG_SIDE_LOG2 = 5
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  ipguPkg::scale_t     scaleShift,
    input  logic                issueEn,
    output ipguPkg::frameRead_t readReq
);

    localparam int WIN_CNT_W = $clog2(ipguPkg::WIN_PIX);

    // Scaled coordinates
    logic [IMG_SIDE_LOG2-1:0] scaledX;
    logic [IMG_SIDE_LOG2-1:0] scaledY;

    // Position inside the current window
    logic [WIN_CNT_W-1:0] winCnt;

    // Last scaled coordinate, (side >> shift) - 1
    logic [IMG_SIDE_LOG2-1:0] maxCoord;

    // Full-resolution coordinates
    logic [IMG_SIDE_LOG2-1:0] frameX;
    logic [IMG_SIDE_LOG2-1:0] frameY;

    logic rowEnd;
    logic colEnd;

    assign maxCoord = {IMG_SIDE_LOG2{1'b1}} >> scaleShift;

    assign rowEnd = (scaledX == maxCoord);
    assign colEnd = (scaledY == maxCoord);

    // Nearest neighbour, pick every 2^shift pixel
    assign frameX = scaledX << scaleShift;
    assign frameY = scaledY << scaleShift;

    ////////////////////////////////////////
    // Raster counters
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset || start) begin
            scaledX <= '0;
            scaledY <= '0;
            winCnt  <= '0;
        end else if (issueEn) begin
            // Window counter wraps every 16 requests
            winCnt <= winCnt + 1'b1;
            if (rowEnd) begin
                scaledX <= '0;
                // Wrap y too at image end
                if (colEnd) begin
                    scaledY <= '0;
                end else begin
                    scaledY <= scaledY + 1'b1;
                end
            end else begin
                scaledX <= scaledX + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Request out
    ////////////////////////////////////////

    // Row in the upper half, zero extended
    always_comb begin
        readReq            = '0;
        readReq.en         = issueEn;
        readReq.addr       = ipguPkg::pixAddr_t'({frameY, frameX});
        readReq.windowLast = (winCnt == WIN_CNT_W'(ipguPkg::WIN_PIX - 1));
        readReq.imageLast  = rowEnd & colEnd;
    end

endmodule

// ==== source/ipguCtrlUnit.sv ====
module ipguCtrlUnit (
    input  logic                clk,
    input  logic                reset,
    input  logic                initIpgu,
    output logic                rdyIpgu,
    input  ipguPkg::frameRead_t readReq,
    input  logic                winAccepted,
    output logic                start,
    output logic                issueEn,
    output ipguPkg::ctrlState_t state
);

    ipguPkg::ctrlState_t nextState;

    // Image end already issued
    logic imageIssued;

    // Request leaving this cycle
    logic issueWinLast;
    logic issueImgLast;

    assign issueWinLast = readReq.en & readReq.windowLast;
    assign issueImgLast = readReq.en & readReq.imageLast;

    ////////////////////////////////////////
    // Job FSM
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ipguPkg::IDLE;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            ipguPkg::IDLE: begin
                // Request phase of the handshake
                if (initIpgu) begin
                    nextState = ipguPkg::ISSUE;
                end
            end
            ipguPkg::ISSUE: begin
                // One window out, wait for the consumer
                if (issueWinLast) begin
                    nextState = ipguPkg::DRAIN;
                end
            end
            ipguPkg::DRAIN: begin
                if (winAccepted) begin
                    if (imageIssued) begin
                        nextState = ipguPkg::DONE;
                    end else begin
                        nextState = ipguPkg::ISSUE;
                    end
                end
            end
            ipguPkg::DONE: begin
                // Release once the host drops its request
                if (!initIpgu) begin
                    nextState = ipguPkg::IDLE;
                end
            end
            default: begin
                nextState = ipguPkg::IDLE;
            end
        endcase
    end

    ////////////////////////////////////////
    // Image end tracking
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset || start) begin
            imageIssued <= 1'b0;
        end else if (issueImgLast) begin
            imageIssued <= 1'b1;
        end
    end

    // Clear the counters as the job is taken
    assign start = (state == ipguPkg::IDLE) & initIpgu;

    // One request per cycle while issuing
    assign issueEn = (state == ipguPkg::ISSUE);

    // Ack phase, held until init falls
    assign rdyIpgu = (state == ipguPkg::DONE);

endmodule

// ==== source/outBuffer.sv ====
module outBuffer (
    input  logic             clk,
    input  logic             reset,
    input  ipguPkg::pixel_t  rdData,
    input  logic             rdValid,
    input  logic             rdWindowLast,
    input  logic             rdyHeu,
    output logic             vldIpgu,
    output ipguPkg::window_t ipguWindow,
    output logic             winAccepted
);

    localparam int PIX_W = ipguPkg::PIX_W;
    localparam int WIN_W = ipguPkg::WIN_W;

    ipguPkg::window_t winQ;

    ////////////////////////////////////////
    // Window shift register
    ////////////////////////////////////////

    // New pixel enters the top byte
    // Oldest pixel ends in byte 0
    always_ff @(posedge clk) begin
        if (rdValid) begin
            winQ <= {rdData, winQ[WIN_W-1:PIX_W]};
        end
    end

    ////////////////////////////////////////
    // Valid flag
    ////////////////////////////////////////

    // Set on the window's last pixel
    // Cleared by the transfer
    always_ff @(posedge clk) begin
        if (reset) begin
            vldIpgu <= 1'b0;
        end else if (rdValid && rdWindowLast) begin
            vldIpgu <= 1'b1;
        end else if (winAccepted) begin
            vldIpgu <= 1'b0;
        end
    end

    // Transfer this cycle
    assign winAccepted = vldIpgu & rdyHeu;

    // No new pixels until the window is taken, so the data holds
    assign ipguWindow = winQ;

endmodule

// ==== source/ipgu.sv ====
module ipgu #(
    parameter int IMG_SIDE_LOG2 = 5
) (
    input  logic                 clk,
    input  logic                 reset,

    // Host memory port
    input  ipguPkg::hostAccess_t hostAccess,
    output ipguPkg::pixel_t      hostRdData,

    // Job handshake
    input  logic                 initIpgu,
    input  ipguPkg::scale_t      scaleShift,
    output logic                 rdyIpgu,

    // Window consumer
    input  logic                 rdyHeu,
    output logic                 vldIpgu,
    output ipguPkg::window_t     ipguWindow
);

    ////////////////////////////////////////
    // Interconnect
    ////////////////////////////////////////

    ipguPkg::frameRead_t readReq;
    ipguPkg::pixel_t     rdData;
    ipguPkg::ctrlState_t ctrlState;

    logic rdValid;
    logic rdWindowLast;
    logic start;
    logic issueEn;
    logic winAccepted;

    // Frame store
    frameRam #(
        .IMG_SIDE_LOG2(IMG_SIDE_LOG2)
    ) frameMem (
        .clk          (clk),
        .hostAccess   (hostAccess),
        .hostRdData   (hostRdData),
        .readReq      (readReq),
        .rdData       (rdData),
        .rdValid      (rdValid),
        .rdWindowLast (rdWindowLast),
        .rdImageLast  ()
    );

    // Scaled raster walk
    ipguAddrCompute #(
        .IMG_SIDE_LOG2(IMG_SIDE_LOG2)
    ) addrCompute (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .scaleShift (scaleShift),
        .issueEn    (issueEn),
        .readReq    (readReq)
    );

    // Job control
    ipguCtrlUnit ctrlUnit (
        .clk         (clk),
        .reset       (reset),
        .initIpgu    (initIpgu),
        .rdyIpgu     (rdyIpgu),
        .readReq     (readReq),
        .winAccepted (winAccepted),
        .start       (start),
        .issueEn     (issueEn),
        .state       (ctrlState)
    );

    // Window packing and output handshake
    outBuffer outBuf (
        .clk          (clk),
        .reset        (reset),
        .rdData       (rdData),
        .rdValid      (rdValid),
        .rdWindowLast (rdWindowLast),
        .rdyHeu       (rdyHeu),
        .vldIpgu      (vldIpgu),
        .ipguWindow   (ipguWindow),
        .winAccepted  (winAccepted)
    );

endmodule

// ==== tb/ipgu_checker.sv ====
module ipguChecker (
    input logic                clk,
    input logic                reset,
    input logic                initIpgu,
    input logic                rdyIpgu,
    input logic                rdyHeu,
    input logic                vldIpgu,
    input ipguPkg::window_t    ipguWindow,
    input ipguPkg::ctrlState_t state
);

    int failCount = 0;

    ////////////////////////////////////////
    // Handshake rules
    ////////////////////////////////////////

    // Window held while the consumer stalls
    holdWindow: assert property (@(posedge clk) disable iff (reset)
        vldIpgu && !rdyHeu |=> vldIpgu && $stable(ipguWindow))
    else begin
        failCount++;
        $error("Window dropped or changed before rdyHeu");
    end

    // Ack only inside a request
    ackInRequest: assert property (@(posedge clk) disable iff (reset)
        $rose(rdyIpgu) |-> initIpgu)
    else begin
        failCount++;
        $error("rdyIpgu rose without initIpgu");
    end

    // Nothing offered between jobs
    quietIdle: assert property (@(posedge clk) disable iff (reset)
        state == ipguPkg::IDLE |-> !vldIpgu)
    else begin
        failCount++;
        $error("vldIpgu high in IDLE");
    end

endmodule

bind ipgu ipguChecker handshakeCheck (
    .clk        (clk),
    .reset      (reset),
    .initIpgu   (initIpgu),
    .rdyIpgu    (rdyIpgu),
    .rdyHeu     (rdyHeu),
    .vldIpgu    (vldIpgu),
    .ipguWindow (ipguWindow),
    .state      (ctrlState)
);

// ==== tb/ipguMonitor.sv ====
module ipguMonitor #(
    parameter int IMG_SIDE_LOG2 = 5
) (
    input  logic                 clk,
    input  logic                 reset,
    input  ipguPkg::hostAccess_t hostAccess,
    input  ipguPkg::pixel_t      hostRdData,
    input  logic                 initIpgu,
    input  ipguPkg::scale_t      scaleShift,
    input  logic                 rdyIpgu,
    input  logic                 rdyHeu,
    input  logic                 vldIpgu,
    input  ipguPkg::window_t     ipguWindow,
    output int                   winErrs,
    output int                   readErrs,
    output int                   protoErrs,
    output int                   windowsSeen
);

    localparam int SIDE      = 1 << IMG_SIDE_LOG2;
    localparam int FRAME_PIX = SIDE * SIDE;

    // Frame as seen on the host port
    ipguPkg::pixel_t model [0:FRAME_PIX-1];

    logic              readPend;
    ipguPkg::pixAddr_t readAddr;
    logic              initPrev;
    logic              rdyPrev;
    logic              resetPrev;
    int                jobShift;
    int                winIdx;

    initial begin
        winErrs     = 0;
        readErrs    = 0;
        protoErrs   = 0;
        windowsSeen = 0;
        readPend    = 1'b0;
        initPrev    = 1'b0;
        rdyPrev     = 1'b0;
        resetPrev   = 1'b0;
        jobShift    = 0;
        winIdx      = 0;
    end

    // Raster order, every 2^shift pixel, pixel 0 in byte 0
    function automatic ipguPkg::window_t predictWindow(input int idx, input int shift);
        ipguPkg::window_t w;
        int scaledSide;
        int n;
        int sx;
        int sy;
        w = '0;
        scaledSide = SIDE >> shift;
        for (int p = 0; p < ipguPkg::WIN_PIX; p++) begin
            n  = idx * ipguPkg::WIN_PIX + p;
            sx = n % scaledSide;
            sy = n / scaledSide;
            w[p*8 +: 8] = model[(sy << shift) * SIDE + (sx << shift)];
        end
        return w;
    endfunction

    function automatic int jobWindows(input int shift);
        return (SIDE >> shift) * (SIDE >> shift) / ipguPkg::WIN_PIX;
    endfunction

    ////////////////////////////////////////
    // Sampling on the rising edge
    ////////////////////////////////////////

    always @(posedge clk) begin
        ipguPkg::window_t expWin;
        // Outputs after a reset edge
        if (resetPrev && (rdyIpgu !== 1'b0 || vldIpgu !== 1'b0)) begin
            $display("rdyIpgu or vldIpgu not low after reset");
            protoErrs++;
        end
        resetPrev = reset;
        if (!reset) begin
            // Host read data, one cycle late
            if (readPend && hostRdData !== model[readAddr]) begin
                $display("ERR hostRdData addr %h: got %h, expected %h",
                         readAddr, hostRdData, model[readAddr]);
                readErrs++;
            end
            if (hostAccess.sel && hostAccess.we) begin
                model[hostAccess.addr] = hostAccess.data;
            end
            readPend = hostAccess.sel && !hostAccess.we;
            readAddr = hostAccess.addr;

            // New job request
            if (initIpgu && !initPrev) begin
                jobShift = scaleShift;
                winIdx   = 0;
            end

            // Window transfer
            if (vldIpgu && rdyHeu) begin
                if (winIdx >= jobWindows(jobShift)) begin
                    $display("Window transferred after the job's last window");
                    protoErrs++;
                end else begin
                    expWin = predictWindow(winIdx, jobShift);
                    if (ipguWindow !== expWin) begin
                        $display("ERR ipguWindow shift %0d window %0d: got %h, expected %h",
                                 jobShift, winIdx, ipguWindow, expWin);
                        winErrs++;
                    end
                end
                winIdx++;
                windowsSeen++;
            end

            // Ack only after the whole job
            if (rdyIpgu && !rdyPrev && winIdx != jobWindows(jobShift)) begin
                $display("rdyIpgu rose after %0d of %0d windows", winIdx, jobWindows(jobShift));
                protoErrs++;
            end
            if (!rdyIpgu && rdyPrev && initIpgu) begin
                $display("rdyIpgu fell while initIpgu was still high");
                protoErrs++;
            end
        end
        initPrev = initIpgu;
        rdyPrev  = rdyIpgu;
    end

endmodule

// ==== tb/ipguTb.sv ====
module ipguTb;

    localparam int IMG_SIDE_LOG2 = 4;
    localparam int SIDE          = 1 << IMG_SIDE_LOG2;
    localparam int FRAME_PIX     = SIDE * SIDE;
    // Frame bytes then up to 8 job bytes
    localparam int VEC_LEN       = FRAME_PIX + 8;

    logic                 clk;
    logic                 reset;
    ipguPkg::hostAccess_t hostAccess;
    ipguPkg::pixel_t      hostRdData;
    logic                 initIpgu;
    ipguPkg::scale_t      scaleShift;
    logic                 rdyIpgu;
    logic                 rdyHeu;
    logic                 vldIpgu;
    ipguPkg::window_t     ipguWindow;

    logic [7:0]  vectors [0:VEC_LEN-1];
    logic [31:0] rndState;
    logic        bpOn;

    int limitCycles = 0;
    int expWindows;
    int jobCount;
    int otherErrs;
    int winErrs;
    int readErrs;
    int protoErrs;
    int windowsSeen;

    ipgu #(
        .IMG_SIDE_LOG2(IMG_SIDE_LOG2)
    ) uut (
        .clk        (clk),
        .reset      (reset),
        .hostAccess (hostAccess),
        .hostRdData (hostRdData),
        .initIpgu   (initIpgu),
        .scaleShift (scaleShift),
        .rdyIpgu    (rdyIpgu),
        .rdyHeu     (rdyHeu),
        .vldIpgu    (vldIpgu),
        .ipguWindow (ipguWindow)
    );

    // Compares everything the DUT returns
    ipguMonitor #(
        .IMG_SIDE_LOG2(IMG_SIDE_LOG2)
    ) watch (
        .clk         (clk),
        .reset       (reset),
        .hostAccess  (hostAccess),
        .hostRdData  (hostRdData),
        .initIpgu    (initIpgu),
        .scaleShift  (scaleShift),
        .rdyIpgu     (rdyIpgu),
        .rdyHeu      (rdyHeu),
        .vldIpgu     (vldIpgu),
        .ipguWindow  (ipguWindow),
        .winErrs     (winErrs),
        .readErrs    (readErrs),
        .protoErrs   (protoErrs),
        .windowsSeen (windowsSeen)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    function automatic logic [31:0] nextRandom(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // (side >> shift) squared over 16 pixels per window
    function automatic int windowsPerJob(input int shift);
        int scaledSide;
        scaledSide = SIDE >> shift;
        return scaledSide * scaledSide / ipguPkg::WIN_PIX;
    endfunction

    function automatic int allErrors();
        return winErrs + readErrs + protoErrs + otherErrs + uut.handshakeCheck.failCount;
    endfunction

    // New consumer ready bit on each falling edge
    task automatic stepCycle();
        @(negedge clk);
        rndState = nextRandom(rndState);
        rdyHeu   = bpOn ? rndState[9] : 1'b1;
    endtask

    task automatic printCounts();
        $display("%s %0d, %s %0d, %s %0d, %s %0d, %s %0d, %s %0d",
                 "window errors", winErrs, "readback errors", readErrs,
                 "protocol errors", protoErrs,
                 "assertion failures", uut.handshakeCheck.failCount,
                 "other errors", otherErrs, "windows checked", windowsSeen);
    endtask

    // Writes all pixels then reads them back pipelined
    task automatic loadFrame();
        ipguPkg::hostAccess_t acc;
        for (int i = 0; i < 2 * FRAME_PIX; i++) begin
            stepCycle();
            acc.sel  = 1'b1;
            acc.we   = (i < FRAME_PIX);
            acc.addr = ipguPkg::pixAddr_t'(i % FRAME_PIX);
            acc.data = vectors[i % FRAME_PIX];
            hostAccess = acc;
        end
        stepCycle();
        hostAccess = '0;
        stepCycle();
    endtask

    // Full four-phase job
    task automatic runJob(input logic [7:0] job);
        stepCycle();
        bpOn       = job[4];
        scaleShift = ipguPkg::scale_t'(job[3:0]);
        initIpgu   = 1'b1;
        while (rdyIpgu !== 1'b1) begin
            stepCycle();
        end
        // Request stays up a few cycles past the ack
        repeat (3) begin
            stepCycle();
        end
        initIpgu = 1'b0;
        while (rdyIpgu !== 1'b0) begin
            stepCycle();
        end
        bpOn = 1'b0;
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        reset      = 1'b1;
        hostAccess = '0;
        initIpgu   = 1'b0;
        scaleShift = '0;
        rdyHeu     = 1'b1;
        bpOn       = 1'b0;
        rndState   = 32'h16e9_3eae;
        otherErrs  = 0;
        $readmemh("tb/ipguVectors.hex", vectors);

        // Job list ends at a zero byte
        jobCount   = 0;
        expWindows = 0;
        for (int i = FRAME_PIX; i < VEC_LEN && vectors[i] != 8'h00; i++) begin
            jobCount++;
            expWindows += windowsPerJob(vectors[i][3:0]);
        end
        limitCycles = 40 * expWindows + 600 * (jobCount + 1);

        repeat (5) @(negedge clk);
        reset = 1'b0;

        loadFrame();
        for (int j = 0; j < jobCount; j++) begin
            runJob(vectors[FRAME_PIX + j]);
        end
        repeat (4) stepCycle();

        if (windowsSeen != expWindows) begin
            $display("Wrong number of windows, %0d seen and %0d expected",
                     windowsSeen, expWindows);
            otherErrs++;
        end
        printCounts();
        if (allErrors() == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (limitCycles > 0);
        repeat (limitCycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", limitCycles);
        otherErrs++;
        printCounts();
        $display("tests failed");
        $finish;
    end

endmodule

// ==== tb/ipguVectors.hex ====
// Bytes 0 to 255: 16x16 frame, one row per line, pixel = address ^ 5a
// Then job bytes: low nibble shift, bit 4 random back-pressure, 00 ends the list
5a 5b 58 59 5e 5f 5c 5d 52 53 50 51 56 57 54 55
4a 4b 48 49 4e 4f 4c 4d 42 43 40 41 46 47 44 45
7a 7b 78 79 7e 7f 7c 7d 72 73 70 71 76 77 74 75
6a 6b 68 69 6e 6f 6c 6d 62 63 60 61 66 67 64 65
1a 1b 18 19 1e 1f 1c 1d 12 13 10 11 16 17 14 15
0a 0b 08 09 0e 0f 0c 0d 02 03 00 01 06 07 04 05
3a 3b 38 39 3e 3f 3c 3d 32 33 30 31 36 37 34 35
2a 2b 28 29 2e 2f 2c 2d 22 23 20 21 26 27 24 25
da db d8 d9 de df dc dd d2 d3 d0 d1 d6 d7 d4 d5
ca cb c8 c9 ce cf cc cd c2 c3 c0 c1 c6 c7 c4 c5
fa fb f8 f9 fe ff fc fd f2 f3 f0 f1 f6 f7 f4 f5
ea eb e8 e9 ee ef ec ed e2 e3 e0 e1 e6 e7 e4 e5
9a 9b 98 99 9e 9f 9c 9d 92 93 90 91 96 97 94 95
8a 8b 88 89 8e 8f 8c 8d 82 83 80 81 86 87 84 85
ba bb b8 b9 be bf bc bd b2 b3 b0 b1 b6 b7 b4 b5
aa ab a8 a9 ae af ac ad a2 a3 a0 a1 a6 a7 a4 a5
// Jobs, shift 0 runs with back-pressure only
01 02 10 11 12 02 01 00

// ==== src.f ====
source/ipguPkg.sv
source/frameRam.sv
source/ipguAddrCompute.sv
source/ipguCtrlUnit.sv
source/outBuffer.sv
source/ipgu.sv
tb/ipgu_checker.sv
tb/ipguMonitor.sv
tb/ipguTb.sv

// ==== Bender.yml ====
package:
  name: ipgu

sources:
  - source/ipguPkg.sv
  - source/frameRam.sv
  - source/ipguAddrCompute.sv
  - source/ipguCtrlUnit.sv
  - source/outBuffer.sv
  - source/ipgu.sv
  - target: test
    files:
      - tb/ipgu_checker.sv
      - tb/ipguMonitor.sv
      - tb/ipguTb.sv
